//--- logic/rack_defs.svh
`ifndef RACK_DEFS_SVH
`define RACK_DEFS_SVH

// widths
`define WORD_W           32
`define PIPE_W           16
`define WAVE_DEPTH_LOG2  10             // 1024 samples per waveform
`define FIXED_SHIFT      6              // integer rate to fixed point current
`define NOISE_BITS       10             // lsbs of the current replaced by noise

// trigger strobe bits
`define TRIG_LCE         9
`define TRIG_DIVIDER     7

// control word bits
`define CTL_RESET_GLOBAL 0
`define CTL_FROM_PIPE    1
`define CTL_RESET_SIM    2

// register values after reset
`define LCE_DEFAULT      32'h3F800000   // 1.0 in single precision
`define DIVIDER_DEFAULT  32'd381        // half-periods, about 0.5x real time

// noise generator
`define LFSR_SEED_IA     32'h1
`define LFSR_SEED_II     32'h2
`define LFSR_TAP_A       32
`define LFSR_TAP_B       22
`define LFSR_TAP_C       2
`define LFSR_TAP_D       1

`endif

//--- logic/rack_pkg.sv
package rack_pkg;

    `include "rack_defs.svh"

    // host side words
    typedef logic [`WORD_W-1:0] word_t;         // parameter or data word
    typedef logic [`PIPE_W-1:0] pipe_word_t;    // one pipe word or one wire half
    typedef logic [`PIPE_W-1:0] trig_t;         // one strobe bit per triggered register

    // simulation side words
    typedef logic [`WORD_W-1:0] time_tag_t;     // ticks since reset
    typedef logic [`WORD_W-1:0] rate_t;         // integer afferent rate, pps
    typedef logic [`WORD_W-1:0] current_t;      // fixed point current with noise in the lsbs
    typedef logic [`WORD_W-1:0] count_t;        // spikes in one tick period

    // waveform memory address
    typedef logic [`WAVE_DEPTH_LOG2-1:0] addr_t;

    // two pipe words make one sample, low half first
    typedef enum logic
    {
        LOW_HALF,
        HIGH_HALF
    } pipe_phase_t;

endpackage

//--- logic/param_bank.sv
`timescale 1ns/1ps
`include "rack_defs.svh"

module param_bank
    import rack_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  trig_t      i_trig,
    input  pipe_word_t i_wire_hi,
    input  pipe_word_t i_wire_lo,
    input  pipe_word_t i_ctl,
    input  logic       i_ext_reset,
    input  logic       i_sim_tick,
    output word_t      o_lce,
    output word_t      o_half_cnt,
    output logic       o_reset_any,     // drives the timebase reset
    output logic       o_reset_sim,     // drives players, formatters, tallies
    output logic       o_from_pipe
);

    word_t wire_word;       // host data word, hi half on top
    logic  ext_reset_q;     // connector reset as seen at the last tick

    assign wire_word = {i_wire_hi, i_wire_lo};

    // each register loads the wire word on the edge its strobe is high
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_lce      <= `LCE_DEFAULT;
            o_half_cnt <= `DIVIDER_DEFAULT;
        end
        else
        begin
            if (i_trig[`TRIG_LCE])
                o_lce <= wire_word;
            if (i_trig[`TRIG_DIVIDER])
                o_half_cnt <= wire_word;        // new rate takes hold at the next wrap
        end
    end

    // sample once per tick, glitches between ticks never reach reset_sim
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            ext_reset_q <= 1'b0;
        else if (i_sim_tick)
            ext_reset_q <= i_ext_reset;
    end

    // control word decode
    assign o_reset_any = reset_global | i_ctl[`CTL_RESET_GLOBAL];
    assign o_reset_sim = o_reset_any | i_ctl[`CTL_RESET_SIM] | ext_reset_q; // global implies sim
    assign o_from_pipe = i_ctl[`CTL_FROM_PIPE];

endmodule

//--- logic/sim_timebase.sv
`timescale 1ns/1ps

module sim_timebase
    import rack_pkg::*;
(
    input  logic      ep50trig,
    input  logic      i_reset,          // pin reset or host reset request
    input  word_t     i_half_cnt,       // half-period of the tick in clocks
    output logic      o_sim_tick,       // one clock wide, every 2*half clocks
    output time_tag_t o_time            // ticks since reset
);

    word_t half_eff;        // half-count with zero read as one
    word_t last_cnt;        // final count of one tick period
    word_t div_cnt;

    assign half_eff = (i_half_cnt == '0) ? word_t'(1) : i_half_cnt;
    assign last_cnt = (half_eff << 1) - word_t'(1);

    // divider, >= also catches a shorter period loaded mid-count
    always_ff @(posedge ep50trig or posedge i_reset)
    begin
        if (i_reset)
        begin
            div_cnt    <= '0;
            o_sim_tick <= 1'b0;
        end
        else if (div_cnt >= last_cnt)
        begin
            div_cnt    <= '0;
            o_sim_tick <= 1'b1;     // registered, first tick 2*half clocks after release
        end
        else
        begin
            div_cnt    <= div_cnt + word_t'(1);
            o_sim_tick <= 1'b0;
        end
    end

    // time tag steps the cycle after each tick
    always_ff @(posedge ep50trig or posedge i_reset)
    begin
        if (i_reset)
            o_time <= '0;
        else if (o_sim_tick)
            o_time <= o_time + time_tag_t'(1);
    end

endmodule

//--- logic/wave_player.sv
`timescale 1ns/1ps
`include "rack_defs.svh"

module wave_player
    import rack_pkg::*;
(
    input  logic       ep50trig,
    input  logic       i_reset_sim,
    input  logic       i_pipe_write,    // one pulse per 16-bit word
    input  pipe_word_t i_pipe_data,
    input  logic       i_from_pipe,     // play memory, else follow lce
    input  word_t      i_lce,
    input  logic       i_sim_tick,
    output word_t      o_wave
);

    localparam int DEPTH = 1 << `WAVE_DEPTH_LOG2;

    word_t       mem [0:DEPTH-1];   // sample store
    pipe_phase_t phase;             // which half the next pipe word is
    pipe_word_t  lo_half;           // low half waiting for its partner
    addr_t       wr_ptr;            // next write slot, also the fill length
    addr_t       rd_ptr;            // next sample to play
    addr_t       rd_next;
    logic        sample_done;       // high half arriving completes a sample

    assign sample_done = i_pipe_write && (phase == HIGH_HALF);
    assign rd_next     = rd_ptr + addr_t'(1);

    // pipe assembly
    always_ff @(posedge ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            phase  <= LOW_HALF;
            wr_ptr <= '0;
        end
        else if (i_pipe_write)
        begin
            phase <= (phase == LOW_HALF) ? HIGH_HALF : LOW_HALF;
            if (phase == HIGH_HALF)
                wr_ptr <= wr_ptr + addr_t'(1);
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (i_pipe_write && (phase == LOW_HALF))
            lo_half <= i_pipe_data;
        if (sample_done)
            mem[wr_ptr] <= {i_pipe_data, lo_half};
    end

    // playback, one sample per tick with wrap at the fill length
    always_ff @(posedge ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            rd_ptr <= '0;
            o_wave <= '0;
        end
        else if (!i_from_pipe)
            o_wave <= i_lce;                // triggered length passes through
        else if (i_sim_tick && (wr_ptr != '0))
        begin
            o_wave <= mem[rd_ptr];
            rd_ptr <= (rd_next == wr_ptr) ? addr_t'(0) : rd_next;
        end
    end

endmodule

//--- logic/afferent_noise.sv
`timescale 1ns/1ps
`include "rack_defs.svh"

module afferent_noise
    import rack_pkg::*;
#(
    parameter word_t SEED = `LFSR_SEED_IA   // instances need distinct seeds
)
(
    input  logic     ep50trig,
    input  logic     i_reset_sim,
    input  rate_t    i_rate,        // integer afferent rate
    output current_t o_current      // fixed point rate with noisy lsbs
);

    word_t    lfsr;
    logic     feedback;
    current_t fixed_rate;

    // fibonacci taps 32, 22, 2, 1
    assign feedback = lfsr[`LFSR_TAP_A-1] ^ lfsr[`LFSR_TAP_B-1]
                    ^ lfsr[`LFSR_TAP_C-1] ^ lfsr[`LFSR_TAP_D-1];

    assign fixed_rate = current_t'(i_rate << `FIXED_SHIFT);

    always_ff @(posedge ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            lfsr      <= SEED;      // held at seed while sim is in reset
            o_current <= '0;
        end
        else
        begin
            lfsr      <= {lfsr[`WORD_W-2:0], feedback};    // one step per clock
            o_current <= {fixed_rate[`WORD_W-1:`NOISE_BITS], lfsr[`NOISE_BITS-1:0]};
        end
    end

endmodule

//--- logic/spike_tally.sv
`timescale 1ns/1ps

module spike_tally
    import rack_pkg::*;
(
    input  logic   ep50trig,
    input  logic   i_reset_sim,
    input  logic   i_spike,         // one clock per spike
    input  logic   i_sim_tick,
    output count_t o_count          // spikes in the last tick period
);

    count_t run_cnt;        // spikes since the last tick
    count_t run_next;       // count including this cycle's pulse

    assign run_next = run_cnt + count_t'(i_spike);

    always_ff @(posedge ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            run_cnt <= '0;
            o_count <= '0;
        end
        else if (i_sim_tick)
        begin
            o_count <= run_next;    // a pulse on the tick cycle closes this period
            run_cnt <= '0;
        end
        else
        begin
            run_cnt <= run_next;
        end
    end

endmodule

//--- logic/rack_top.sv
`timescale 1ns/1ps
`include "rack_defs.svh"

module rack_top
    import rack_pkg::*;
(
    input  logic       ep50trig,        // fabric clock
    input  logic       reset_global,
    input  trig_t      i_trig,          // one-cycle register strobes
    input  pipe_word_t i_wire_hi,
    input  pipe_word_t i_wire_lo,
    input  pipe_word_t i_ctl,           // control level word
    input  logic       i_ext_reset,     // rack connector reset request
    input  logic       i_pipe_write,
    input  pipe_word_t i_pipe_data,
    input  logic       i_tref_write,
    input  pipe_word_t i_tref_data,
    input  rate_t      i_ia_rate,
    input  rate_t      i_ii_rate,
    input  logic       i_spike_ia,
    input  logic       i_spike_ii,
    output logic       o_sim_tick,
    output time_tag_t  o_time,
    output word_t      o_wave,          // stimulus length
    output word_t      o_tref_wave,     // latency time reference
    output current_t   o_current_ia,
    output current_t   o_current_ii,
    output count_t     o_count_ia,
    output count_t     o_count_ii,
    output logic       o_reset_sim
);

    word_t lce;             // triggered length value
    word_t half_cnt;        // divider half-period
    logic  reset_any;       // pin reset or host reset request
    logic  from_pipe;       // stimulus plays its pipe instead of lce

    param_bank bank_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_trig(i_trig),
        .i_wire_hi(i_wire_hi), .i_wire_lo(i_wire_lo), .i_ctl(i_ctl),
        .i_ext_reset(i_ext_reset), .i_sim_tick(o_sim_tick),
        .o_lce(lce), .o_half_cnt(half_cnt), .o_reset_any(reset_any),
        .o_reset_sim(o_reset_sim), .o_from_pipe(from_pipe)
    );

    sim_timebase timebase_i (
        .ep50trig(ep50trig), .i_reset(reset_any), .i_half_cnt(half_cnt),
        .o_sim_tick(o_sim_tick), .o_time(o_time)
    );

    wave_player stim_player_i (
        .ep50trig(ep50trig), .i_reset_sim(o_reset_sim), .i_pipe_write(i_pipe_write),
        .i_pipe_data(i_pipe_data), .i_from_pipe(from_pipe), .i_lce(lce),
        .i_sim_tick(o_sim_tick), .o_wave(o_wave)
    );

    // time reference always streams its pipe
    wave_player tref_player_i (
        .ep50trig(ep50trig), .i_reset_sim(o_reset_sim), .i_pipe_write(i_tref_write),
        .i_pipe_data(i_tref_data), .i_from_pipe(1'b1), .i_lce(lce),
        .i_sim_tick(o_sim_tick), .o_wave(o_tref_wave)
    );

    afferent_noise #(.SEED(`LFSR_SEED_IA)) noise_ia_i (
        .ep50trig(ep50trig), .i_reset_sim(o_reset_sim), .i_rate(i_ia_rate),
        .o_current(o_current_ia)
    );

    afferent_noise #(.SEED(`LFSR_SEED_II)) noise_ii_i (
        .ep50trig(ep50trig), .i_reset_sim(o_reset_sim), .i_rate(i_ii_rate),
        .o_current(o_current_ii)
    );

    spike_tally tally_ia_i (
        .ep50trig(ep50trig), .i_reset_sim(o_reset_sim), .i_spike(i_spike_ia),
        .i_sim_tick(o_sim_tick), .o_count(o_count_ia)
    );

    spike_tally tally_ii_i (
        .ep50trig(ep50trig), .i_reset_sim(o_reset_sim), .i_spike(i_spike_ii),
        .i_sim_tick(o_sim_tick), .o_count(o_count_ii)
    );

endmodule

//--- bench/rack_assert.sv
`timescale 1ns/1ps
`include "rack_defs.svh"

module rack_assert
(
    input logic ep50trig,
    input logic i_reset,
    input logic i_tick,
    input logic i_ctl_sim,          // control word sim reset bit
    input logic i_ext_reset,        // connector reset request
    input logic i_reset_sim
);

    // tick is one clock wide
    tick_single: assert property (@(posedge ep50trig) disable iff (i_reset) i_tick |=> !i_tick)
        else $error("simulation tick high on two consecutive cycles");

    ctl_to_sim: assert property (@(posedge ep50trig) i_ctl_sim |-> i_reset_sim)
        else $error("control sim reset bit set while reset_sim is low");

    // connector reset seen on a tick holds sim in reset from the next cycle
    ext_to_sim: assert property (@(posedge ep50trig) disable iff (i_reset)
        (i_tick && i_ext_reset) |=> i_reset_sim)
        else $error("connector reset captured on a tick did not raise reset_sim");

endmodule

bind sim_timebase rack_assert timebase_chk_i (
    .ep50trig(ep50trig), .i_reset(i_reset), .i_tick(o_sim_tick),
    .i_ctl_sim(1'b0), .i_ext_reset(1'b0), .i_reset_sim(1'b0)
);

bind param_bank rack_assert bank_chk_i (
    .ep50trig(ep50trig), .i_reset(reset_global), .i_tick(i_sim_tick),
    .i_ctl_sim(i_ctl[`CTL_RESET_SIM]), .i_ext_reset(i_ext_reset), .i_reset_sim(o_reset_sim)
);

//--- bench/rack_tb.sv
`timescale 1ns/1ps
`include "rack_defs.svh"

module rack_tb
    import rack_pkg::*;
();

    localparam int         TICK_LIMIT  = 64;           // cycles, well above the longest test period
    localparam word_t      BIG_HALF    = 32'd1000;     // parks the divider while pipes fill
    localparam pipe_word_t CTL_PLAY    = 16'(1) << `CTL_FROM_PIPE;
    localparam pipe_word_t CTL_SIM_RST = 16'(1) << `CTL_RESET_SIM;
    localparam pipe_word_t CTL_HOST    = 16'(1) << `CTL_RESET_GLOBAL;
    localparam current_t   HIGH_MASK   = ~current_t'((1 << `NOISE_BITS) - 1);
    localparam current_t   RATE_SCALE  = current_t'(2 ** `FIXED_SHIFT);   // current lsbs per pps

    logic       ep50trig;
    logic       reset_global;
    trig_t      i_trig;
    pipe_word_t i_wire_hi, i_wire_lo, i_ctl;
    logic       i_ext_reset;
    logic       i_pipe_write, i_tref_write;
    pipe_word_t i_pipe_data, i_tref_data;
    rate_t      i_ia_rate, i_ii_rate;
    logic       i_spike_ia, i_spike_ii;
    logic       o_sim_tick, o_reset_sim;
    time_tag_t  o_time;
    word_t      o_wave, o_tref_wave;
    current_t   o_current_ia, o_current_ii;
    count_t     o_count_ia, o_count_ii;

    word_t rng = 32'hc54e;      // stimulus lfsr state
    word_t half;                // divider half-count under test
    word_t stim_q[$];           // model of the stimulus memory
    word_t tref_q[$];           // model of the time reference memory

    rack_top dut_i (.*);

    initial
    begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;    // 4 ns period
    end

    // fibonacci lfsr with taps 32 22 2 1, one step per bit returned
    function automatic word_t rand_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
            rng = {rng[30:0], fb};
            r   = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic mismatch(input string what, input word_t got, input word_t exp);
        fail_run($sformatf("FAILED at time %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
            mismatch(what, got, exp);
    endtask

    task automatic check_time(input string what, input time_tag_t got, input time_tag_t exp);
        if (got !== exp)
            mismatch(what, got, exp);
    endtask

    task automatic check_current(input string what, input current_t got, input current_t exp);
        if (got !== exp)
            mismatch(what, got, exp);
    endtask

    task automatic check_count(input string what, input count_t got, input count_t exp);
        if (got !== exp)
            mismatch(what, got, exp);
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            mismatch(what, word_t'(got), word_t'(exp));
    endtask

    // returns on the negedge where the tick is high, gap is cycles since the call
    task automatic wait_tick(output int gap);
        gap = 1;
        @(negedge ep50trig);
        while (o_sim_tick !== 1'b1)
        begin
            if (gap >= TICK_LIMIT)
                fail_run($sformatf("timeout: no simulation tick within %0d cycles", TICK_LIMIT));
            gap++;
            @(negedge ep50trig);
        end
    endtask

    task automatic load_reg(input int bit_pos, input word_t val);
        @(posedge ep50trig);
        i_wire_hi <= val[31:16];
        i_wire_lo <= val[15:0];
        i_trig    <= trig_t'(1) << bit_pos;     // bank loads on the next edge
        @(posedge ep50trig);
        i_trig    <= '0;
    endtask

    task automatic set_ctl(input pipe_word_t val);
        @(posedge ep50trig);
        i_ctl <= val;
    endtask

    // low half then high half, one write per cycle
    task automatic push_sample(input logic tref, input word_t val);
        for (int h = 0; h < 2; h++)
        begin
            @(posedge ep50trig);
            i_pipe_write <= !tref;
            i_tref_write <= tref;
            i_pipe_data  <= (h == 0) ? val[15:0] : val[31:16];
            i_tref_data  <= (h == 0) ? val[15:0] : val[31:16];
        end
        @(posedge ep50trig);
        i_pipe_write <= 1'b0;
        i_tref_write <= 1'b0;
    endtask

    // fill both players with no tick running, then follow two wraps of the longest
    task automatic play_check();
        int    n_stim;
        int    n_tref;
        int    gap;
        word_t v;
        stim_q.delete();
        tref_q.delete();
        n_stim = 1 + int'(rand_bits(3));
        n_tref = 1 + int'(rand_bits(3));
        load_reg(`TRIG_DIVIDER, BIG_HALF);
        for (int i = 0; i < n_stim; i++)
        begin
            v = rand_bits(32);
            stim_q.push_back(v);
            push_sample(1'b0, v);
        end
        for (int i = 0; i < n_tref; i++)
        begin
            v = rand_bits(32);
            tref_q.push_back(v);
            push_sample(1'b1, v);
        end
        set_ctl(CTL_PLAY);
        load_reg(`TRIG_DIVIDER, half);          // counter already past the end, tick follows
        for (int k = 0; k < 17; k++)
        begin
            wait_tick(gap);
            @(negedge ep50trig);                // sample shows one cycle after the tick
            check_word("stimulus sample", o_wave, stim_q[k % n_stim]);
            check_word("time reference sample", o_tref_wave, tref_q[k % n_tref]);
        end
    endtask

    initial
    begin
        int        gap;
        int        checked;
        logic      pending;
        logic      ia_moved, ii_moved;
        logic [`NOISE_BITS-1:0] noise_ia0, noise_ii0;
        word_t     lce_val, spikes;
        time_tag_t t_seen;
        count_t    run_ia, run_ii, exp_ia, exp_ii;
        rate_t     rate_ia, rate_ii;
        reset_global = 1'b1;
        i_trig       = '0;
        i_wire_hi    = '0;
        i_wire_lo    = '0;
        i_ctl        = '0;
        i_ext_reset  = 1'b0;
        i_pipe_write = 1'b0;
        i_pipe_data  = '0;
        i_tref_write = 1'b0;
        i_tref_data  = '0;
        i_ia_rate    = '0;
        i_ii_rate    = '0;
        i_spike_ia   = 1'b0;
        i_spike_ii   = 1'b0;
        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;

        // lce default, then a host load
        @(posedge ep50trig);
        @(negedge ep50trig);
        check_word("lce after reset", o_wave, `LCE_DEFAULT);
        lce_val = rand_bits(32);
        load_reg(`TRIG_LCE, lce_val);
        @(posedge ep50trig);
        @(negedge ep50trig);
        check_word("lce after load", o_wave, lce_val);

        // tick spacing and time tag from a host reset
        half = word_t'(2) + rand_bits(3);
        load_reg(`TRIG_DIVIDER, half);
        set_ctl(CTL_HOST);
        set_ctl('0);
        wait_tick(gap);
        check_time("time at first tick", o_time, '0);
        for (int k = 1; k <= 4; k++)
        begin
            wait_tick(gap);
            check_word("tick spacing", word_t'(gap), half << 1);
            check_time("time tag", o_time, time_tag_t'(k));
        end
        @(negedge ep50trig);
        check_time("time after last tick", o_time, 32'd5);

        play_check();

        // afferent currents, rate on top and noise underneath
        ia_moved = 1'b0;
        ii_moved = 1'b0;
        for (int k = 0; k < 32; k++)
        begin
            @(posedge ep50trig);
            rate_ia = rand_bits(32);
            rate_ii = rand_bits(32);
            i_ia_rate <= rate_ia;
            i_ii_rate <= rate_ii;
            @(posedge ep50trig);
            @(negedge ep50trig);
            check_current("ia current", o_current_ia & HIGH_MASK,
                          (rate_ia * RATE_SCALE) & HIGH_MASK);
            check_current("ii current", o_current_ii & HIGH_MASK,
                          (rate_ii * RATE_SCALE) & HIGH_MASK);
            if (k == 0)
            begin
                noise_ia0 = o_current_ia[`NOISE_BITS-1:0];
                noise_ii0 = o_current_ii[`NOISE_BITS-1:0];
            end
            if (o_current_ia[`NOISE_BITS-1:0] != noise_ia0)
                ia_moved = 1'b1;
            if (o_current_ii[`NOISE_BITS-1:0] != noise_ii0)
                ii_moved = 1'b1;
        end
        if (!ia_moved || !ii_moved)
            fail_run("noise bits of an afferent current stayed constant for 32 samples");

        // spike tallies against a per period model
        run_ia  = '0;
        run_ii  = '0;
        checked = 0;
        pending = 1'b0;
        for (int c = 0; c < 400 && checked < 6; c++)
        begin
            @(posedge ep50trig);
            spikes = rand_bits(2);
            i_spike_ia <= spikes[0];
            i_spike_ii <= spikes[1];
            @(negedge ep50trig);
            if (pending)
            begin
                check_count("ia spike count", o_count_ia, exp_ia);
                check_count("ii spike count", o_count_ii, exp_ii);
                checked++;
                pending = 1'b0;
            end
            run_ia = run_ia + count_t'(i_spike_ia);     // pulse on the tick cycle counts here
            run_ii = run_ii + count_t'(i_spike_ii);
            if (o_sim_tick)
            begin
                exp_ia  = run_ia;
                exp_ii  = run_ii;
                run_ia  = '0;
                run_ii  = '0;
                pending = 1'b1;
            end
        end
        if (checked < 6)
            fail_run("timeout: spike tallies did not reach six tick periods");

        // sim reset from the control word, time keeps running
        @(posedge ep50trig);
        i_spike_ia <= 1'b0;
        i_spike_ii <= 1'b0;
        i_ctl      <= CTL_PLAY | CTL_SIM_RST;
        @(negedge ep50trig);
        check_flag("reset_sim from control bit", o_reset_sim, 1'b1);
        check_count("ia count in sim reset", o_count_ia, '0);
        check_count("ii count in sim reset", o_count_ii, '0);
        check_word("stimulus in sim reset", o_wave, '0);
        wait_tick(gap);
        t_seen = o_time;
        @(negedge ep50trig);
        check_time("time during sim reset", o_time, t_seen + time_tag_t'(1));
        set_ctl(CTL_PLAY);
        play_check();                           // playback restarts from sample zero

        // connector reset held across a tick
        @(posedge ep50trig);
        i_ext_reset <= 1'b1;
        i_spike_ia  <= 1'b1;                    // counts build up until the capture
        wait_tick(gap);
        @(negedge ep50trig);
        check_flag("reset_sim from connector", o_reset_sim, 1'b1);
        check_count("ia count after connector reset", o_count_ia, '0);
        check_word("stimulus after connector reset", o_wave, '0);
        @(posedge ep50trig);
        i_ext_reset <= 1'b0;
        i_spike_ia  <= 1'b0;
        wait_tick(gap);
        @(negedge ep50trig);
        check_flag("reset_sim after release", o_reset_sim, 1'b0);
        wait_tick(gap);
        @(negedge ep50trig);
        check_word("stimulus with empty memory", o_wave, '0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+logic
logic/rack_pkg.sv
logic/param_bank.sv
logic/sim_timebase.sv
logic/wave_player.sv
logic/afferent_noise.sv
logic/spike_tally.sv
logic/rack_top.sv
bench/rack_assert.sv
bench/rack_tb.sv

//--- Makefile
# verilator build and run of the rack front end testbench
TOP = rack_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
